/* scroll_defs.svh */
// scroll renderer sizes
// line geometry, raster window, tile map width and the blank pixel code
`ifndef SCROLL_DEFS_SVH
`define SCROLL_DEFS_SVH

// active pixels rendered per line
`define SCROLL_LINE_W   64

// full horizontal count, active plus blanking
`define SCROLL_H_TOTAL  80

// first active hdump, screen x = hdump - 8
`define SCROLL_H_START  8

// tiles per map row, same for all three layers
`define SCROLL_MAP_COLS 32

// shown outside the window and after reset
`define SCROLL_BLANK    11'h1ff

`endif

/* scroll_pkg.sv */
// scroll renderer types
// vector widths, layer select and the per-layer register set
package scroll_pkg;

    // tile code bits 6..0 over a 4-bit colour
    typedef logic [10:0] pxl_t;

    typedef logic [16:0] vram_addr_t;   // word address
    typedef logic [19:0] rom_addr_t;    // 32-bit word address

    // raster counts
    typedef logic [8:0] hcnt_t;
    typedef logic [8:0] vcnt_t;

    // one layer's map base and scroll offsets
    typedef struct packed {
        logic [15:0] base;
        logic [15:0] hpos;
        logic [15:0] vpos;
    } scroll_reg_t;

    // layer 1: 8 px tiles, layer 2: 16 px, layer 3: 32 px
    typedef enum logic [1:0] {
        LAYER1,
        LAYER2,
        LAYER3
    } layer_e;

endpackage

/* scroll_seq.sv */
// scroll line sequencer
// catches the line start, swaps the line buffer halves and runs
// layers 1, 2 and 3 through the tile fetcher one after another
`timescale 1ns/100ps

module scroll_seq (
    input  logic                    rst,
    input  logic                    clk,
    input  logic                    start,
    input  scroll_pkg::scroll_reg_t layer1_reg,
    input  scroll_pkg::scroll_reg_t layer2_reg,
    input  scroll_pkg::scroll_reg_t layer3_reg,
    input  logic                    fetch_done,
    input  logic                    buf_wr,
    output logic                    fetch_start,
    output logic                    fetch_stop,
    output scroll_pkg::scroll_reg_t cur_reg,
    output scroll_pkg::layer_e      cur_layer,
    output logic [2:0]              wr_en,
    output logic                    wr_half,
    output logic                    rd_half,
    output logic                    done,
    output logic                    busy
);
    import scroll_pkg::*;

    logic   last_start;
    logic   req;        // line start waiting for an idle sequencer
    layer_e st;

    assign fetch_stop = start & ~last_start;   // rising edge of start
    assign cur_layer  = st;

    // steer the fetcher writes into the active layer's buffer
    always_comb begin
        wr_en = 3'b000;
        if (buf_wr && busy) begin
            case (st)
                LAYER1:  wr_en = 3'b001;
                LAYER2:  wr_en = 3'b010;
                default: wr_en = 3'b100;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_start  <= 1'b0;
            req         <= 1'b0;
            busy        <= 1'b0;
            st          <= LAYER1;
            cur_reg     <= '0;
            fetch_start <= 1'b0;
            done        <= 1'b0;
            rd_half     <= 1'b0;
            wr_half     <= 1'b1;
        end else begin
            last_start  <= start;
            fetch_start <= 1'b0;
            done        <= 1'b0;
            if (req && !busy) begin
                wr_half     <= ~wr_half;    // render into the half just released
                req         <= 1'b0;
                busy        <= 1'b1;
                st          <= LAYER1;
                cur_reg     <= layer1_reg;
                fetch_start <= 1'b1;
            end else if (busy && fetch_done) begin
                case (st)
                    LAYER1: begin
                        st          <= LAYER2;
                        cur_reg     <= layer2_reg;
                        fetch_start <= 1'b1;
                    end
                    LAYER2: begin
                        st          <= LAYER3;
                        cur_reg     <= layer3_reg;
                        fetch_start <= 1'b1;
                    end
                    default: begin
                        done <= 1'b1;   // whole line in the buffers
                        busy <= 1'b0;
                    end
                endcase
            end
            // a new line start aborts any render in progress
            if (fetch_stop) begin
                req         <= 1'b1;
                rd_half     <= ~rd_half;
                busy        <= 1'b0;
                fetch_start <= 1'b0;
            end
        end
    end

endmodule

/* tile_fetch.sv */
// tile fetcher for one scroll layer
// reads tile codes from VRAM and pixel rows from the graphics ROM,
// then writes one line of pixels into the line buffer, 8 px per ROM word
`timescale 1ns/100ps
`include "scroll_defs.svh"

module tile_fetch (
    input  logic                    rst,
    input  logic                    clk,
    input  logic                    fetch_start,
    input  logic                    fetch_stop,
    input  scroll_pkg::scroll_reg_t cur_reg,
    input  scroll_pkg::layer_e      cur_layer,
    input  scroll_pkg::vcnt_t       vrender,
    output scroll_pkg::vram_addr_t  vram_addr,
    output logic                    vram_cs,
    input  logic [15:0]             vram_data,
    input  logic                    vram_ok,
    output scroll_pkg::rom_addr_t   rom_addr,
    output logic                    rom_cs,
    input  logic [31:0]             rom_data,
    input  logic                    rom_ok,
    output logic [5:0]              buf_addr,
    output scroll_pkg::pxl_t        buf_data,
    output logic                    buf_wr,
    output logic                    fetch_done
);
    import scroll_pkg::*;

    typedef enum logic [1:0] {F_IDLE, F_TILE, F_ROW, F_DRAW} fst_e;

    fst_e        st;
    layer_e      layer;
    logic [15:0] base;
    logic [9:0]  my;        // map y, fixed for the whole line
    logic [9:0]  mx;        // map x of the current 8 px group
    logic [2:0]  off;       // hpos offset inside the first group
    logic [7:0]  grp_x;     // pixel count at group start
    logic [2:0]  pix;
    logic [15:0] code;
    logic [31:0] rom_row;

    logic [9:0]  mask;
    logic [9:0]  mx_next;
    logic [9:0]  my_start;
    logic [9:0]  mx_start;
    logic [7:0]  cnt;
    logic [7:0]  sx;
    logic        in_range;
    logic        new_tile;
    logic        last_grp;

    // map is 32 tiles square, so it wraps at 32 * tile size
    function automatic logic [9:0] map_mask(input layer_e l);
        case (l)
            LAYER1:  return 10'h0ff;
            LAYER2:  return 10'h1ff;
            default: return 10'h3ff;
        endcase
    endfunction

    function automatic vram_addr_t tile_addr(input logic [15:0] b, input layer_e l,
                                             input logic [9:0] y, input logic [9:0] x);
        logic [4:0] trow;
        logic [4:0] tcol;
        case (l)
            LAYER1: begin
                trow = y[7:3];
                tcol = x[7:3];
            end
            LAYER2: begin
                trow = y[8:4];
                tcol = x[8:4];
            end
            default: begin
                trow = y[9:5];
                tcol = x[9:5];
            end
        endcase
        return vram_addr_t'(b) + vram_addr_t'(trow * `SCROLL_MAP_COLS) + vram_addr_t'(tcol);
    endfunction

    // code * S * S/8 + row in tile * S/8 + word within the row
    function automatic rom_addr_t row_addr(input logic [15:0] c, input layer_e l,
                                           input logic [9:0] y, input logic [9:0] x);
        case (l)
            LAYER1:  return rom_addr_t'({c, 3'b000}) + rom_addr_t'(y[2:0]);
            LAYER2:  return rom_addr_t'({c, 5'b00000}) + rom_addr_t'({y[3:0], x[3]});
            default: return rom_addr_t'({c, 7'b0000000}) + rom_addr_t'({y[4:0], x[4:3]});
        endcase
    endfunction

    assign mask     = map_mask(layer);
    assign mx_next  = (mx + 10'd8) & mask;
    assign my_start = 10'(vrender + cur_reg.vpos) & map_mask(cur_layer);
    assign mx_start = cur_reg.hpos[9:0] & map_mask(cur_layer) & 10'h3f8;
    assign cnt      = grp_x + 8'(pix);
    assign sx       = cnt - 8'(off);
    assign in_range = (cnt >= 8'(off)) && (sx < 8'(`SCROLL_LINE_W));
    assign last_grp = (grp_x + 8'd8) >= (8'(`SCROLL_LINE_W) + 8'(off));

    // next group crosses into a new tile
    always_comb begin
        case (layer)
            LAYER1:  new_tile = 1'b1;
            LAYER2:  new_tile = (mx_next[3] == 1'b0);
            default: new_tile = (mx_next[4:3] == 2'b00);
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= F_IDLE;
            layer      <= LAYER1;
            base       <= '0;
            my         <= '0;
            mx         <= '0;
            off        <= '0;
            grp_x      <= '0;
            pix        <= '0;
            code       <= '0;
            rom_row    <= '0;
            vram_addr  <= '0;
            vram_cs    <= 1'b0;
            rom_addr   <= '0;
            rom_cs     <= 1'b0;
            buf_addr   <= '0;
            buf_data   <= '0;
            buf_wr     <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            buf_wr     <= 1'b0;
            fetch_done <= 1'b0;
            case (st)
                F_IDLE: begin
                    if (fetch_start) begin
                        layer     <= cur_layer;
                        base      <= cur_reg.base;
                        my        <= my_start;
                        mx        <= mx_start;
                        off       <= cur_reg.hpos[2:0];
                        grp_x     <= '0;
                        vram_addr <= tile_addr(cur_reg.base, cur_layer, my_start, mx_start);
                        vram_cs   <= 1'b1;
                        st        <= F_TILE;
                    end
                end
                F_TILE: begin
                    if (vram_cs && vram_ok) begin
                        code     <= vram_data;
                        vram_cs  <= 1'b0;
                        rom_addr <= row_addr(vram_data, layer, my, mx);
                        rom_cs   <= 1'b1;
                        st       <= F_ROW;
                    end
                end
                F_ROW: begin
                    if (rom_cs && rom_ok) begin
                        rom_row <= rom_data;
                        rom_cs  <= 1'b0;
                        pix     <= '0;
                        st      <= F_DRAW;
                    end
                end
                default: begin
                    // one pixel per clock, clipped to the line
                    buf_wr   <= in_range;
                    buf_addr <= sx[5:0];
                    buf_data <= {code[6:0], rom_row[{pix, 2'b00} +: 4]};
                    pix      <= pix + 3'd1;
                    if (pix == 3'd7) begin
                        if (last_grp) begin
                            fetch_done <= 1'b1;
                            st         <= F_IDLE;
                        end else begin
                            grp_x <= grp_x + 8'd8;
                            mx    <= mx_next;
                            if (new_tile) begin
                                vram_addr <= tile_addr(base, layer, my, mx_next);
                                vram_cs   <= 1'b1;
                                st        <= F_TILE;
                            end else begin
                                rom_addr <= row_addr(code, layer, my, mx_next);
                                rom_cs   <= 1'b1;
                                st       <= F_ROW;
                            end
                        end
                    end
                end
            endcase
            if (fetch_stop) begin
                st      <= F_IDLE;
                vram_cs <= 1'b0;
                rom_cs  <= 1'b0;
            end
        end
    end

endmodule

/* line_buf.sv */
// double-buffered line memory for one layer
// write side fills one half while the read side shows the other
`timescale 1ns/100ps
`include "scroll_defs.svh"

module line_buf (
    input  logic             clk,
    input  logic             wr_en,
    input  logic             wr_half,
    input  logic [5:0]       wr_addr,
    input  scroll_pkg::pxl_t wr_data,
    input  logic             rd_half,
    input  logic [5:0]       rd_addr,
    output scroll_pkg::pxl_t rd_data
);
    import scroll_pkg::*;

    // half select sits above the pixel address
    pxl_t mem [0:2*`SCROLL_LINE_W-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{wr_half, wr_addr}] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[{rd_half, rd_addr}];   // one clock read latency
    end

endmodule

/* pxl_out.sv */
// pixel output stage
// latches the three layers on the pixel enable, blank outside the window
`timescale 1ns/100ps
`include "scroll_defs.svh"

module pxl_out (
    input  logic              rst,
    input  logic              clk,
    input  logic              pxl_cen,
    input  scroll_pkg::hcnt_t hdump,
    input  scroll_pkg::pxl_t  pre1,
    input  scroll_pkg::pxl_t  pre2,
    input  scroll_pkg::pxl_t  pre3,
    output logic [5:0]        rd_addr,
    output scroll_pkg::pxl_t  scr1_pxl,
    output scroll_pkg::pxl_t  scr2_pxl,
    output scroll_pkg::pxl_t  scr3_pxl
);
    logic active;
    logic active_q;     // lines up with the registered buffer read

    assign rd_addr = 6'(hdump - 9'(`SCROLL_H_START));
    assign active  = (hdump >= 9'(`SCROLL_H_START)) &&
                     (hdump < 9'(`SCROLL_H_START + `SCROLL_LINE_W));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_q <= 1'b0;
            scr1_pxl <= `SCROLL_BLANK;
            scr2_pxl <= `SCROLL_BLANK;
            scr3_pxl <= `SCROLL_BLANK;
        end else begin
            active_q <= active;
            if (pxl_cen) begin
                if (active_q) begin
                    scr1_pxl <= pre1;
                    scr2_pxl <= pre2;
                    scr3_pxl <= pre3;
                end else begin
                    scr1_pxl <= `SCROLL_BLANK;
                    scr2_pxl <= `SCROLL_BLANK;
                    scr3_pxl <= `SCROLL_BLANK;
                end
            end
        end
    end

endmodule

/* scroll_top.sv */
// three-layer scroll tilemap renderer
// sequencer, shared tile fetcher, one line buffer per layer and output stage
`timescale 1ns/100ps

module scroll_top (
    input  logic                    rst,
    input  logic                    clk,
    input  logic                    pxl_cen,
    input  scroll_pkg::hcnt_t       hdump,
    input  scroll_pkg::vcnt_t       vrender,
    input  logic                    start,
    input  scroll_pkg::scroll_reg_t layer1_reg,
    input  scroll_pkg::scroll_reg_t layer2_reg,
    input  scroll_pkg::scroll_reg_t layer3_reg,
    output scroll_pkg::vram_addr_t  vram_addr,
    output logic                    vram_cs,
    input  logic [15:0]             vram_data,
    input  logic                    vram_ok,
    output scroll_pkg::rom_addr_t   rom_addr,
    output logic                    rom_cs,
    input  logic [31:0]             rom_data,
    input  logic                    rom_ok,
    output scroll_pkg::pxl_t        scr1_pxl,
    output scroll_pkg::pxl_t        scr2_pxl,
    output scroll_pkg::pxl_t        scr3_pxl
);
    import scroll_pkg::*;

    logic        fetch_start, fetch_stop, fetch_done;
    scroll_reg_t cur_reg;
    layer_e      cur_layer;
    logic [2:0]  wr_en;
    logic        wr_half, rd_half;
    logic [5:0]  buf_addr, rd_addr;
    pxl_t        buf_data;
    logic        buf_wr;
    pxl_t        pre1, pre2, pre3;

    // done and busy left open here, probed by the testbench
    scroll_seq seq_inst (
        .rst(rst), .clk(clk), .start(start),
        .layer1_reg(layer1_reg), .layer2_reg(layer2_reg), .layer3_reg(layer3_reg),
        .fetch_done(fetch_done), .buf_wr(buf_wr),
        .fetch_start(fetch_start), .fetch_stop(fetch_stop),
        .cur_reg(cur_reg), .cur_layer(cur_layer), .wr_en(wr_en),
        .wr_half(wr_half), .rd_half(rd_half), .done(), .busy()
    );

    tile_fetch fetch_inst (
        .rst(rst), .clk(clk), .fetch_start(fetch_start), .fetch_stop(fetch_stop),
        .cur_reg(cur_reg), .cur_layer(cur_layer), .vrender(vrender),
        .vram_addr(vram_addr), .vram_cs(vram_cs), .vram_data(vram_data), .vram_ok(vram_ok),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok),
        .buf_addr(buf_addr), .buf_data(buf_data), .buf_wr(buf_wr), .fetch_done(fetch_done)
    );

    line_buf buf1_inst (.clk(clk), .wr_en(wr_en[0]), .wr_half(wr_half), .wr_addr(buf_addr),
        .wr_data(buf_data), .rd_half(rd_half), .rd_addr(rd_addr), .rd_data(pre1));
    line_buf buf2_inst (.clk(clk), .wr_en(wr_en[1]), .wr_half(wr_half), .wr_addr(buf_addr),
        .wr_data(buf_data), .rd_half(rd_half), .rd_addr(rd_addr), .rd_data(pre2));
    line_buf buf3_inst (.clk(clk), .wr_en(wr_en[2]), .wr_half(wr_half), .wr_addr(buf_addr),
        .wr_data(buf_data), .rd_half(rd_half), .rd_addr(rd_addr), .rd_data(pre3));

    pxl_out out_inst (
        .rst(rst), .clk(clk), .pxl_cen(pxl_cen), .hdump(hdump),
        .pre1(pre1), .pre2(pre2), .pre3(pre3), .rd_addr(rd_addr),
        .scr1_pxl(scr1_pxl), .scr2_pxl(scr2_pxl), .scr3_pxl(scr3_pxl)
    );

endmodule

/* tb_clkgen.sv */
// testbench clock and reset source
// 10 ns clock, reset held high for the first two cycles
`timescale 1ns/100ps

module tb_clkgen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;      // released away from any clock edge
    end

endmodule

/* tb_checker.sv */
// output checker for the scroll renderer
// predicts each shown line from the registers of the line before it
// and compares all three layers at every pixel enable
`timescale 1ns/100ps
`include "scroll_defs.svh"

module tb_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic                    start,
    input  scroll_pkg::hcnt_t       hdump,
    input  scroll_pkg::vcnt_t       vrender,
    input  scroll_pkg::scroll_reg_t layer1_reg,
    input  scroll_pkg::scroll_reg_t layer2_reg,
    input  scroll_pkg::scroll_reg_t layer3_reg,
    input  logic                    vram_cs,
    input  logic                    rom_cs,
    input  scroll_pkg::pxl_t        scr1_pxl,
    input  scroll_pkg::pxl_t        scr2_pxl,
    input  scroll_pkg::pxl_t        scr3_pxl,
    output int                      errors,
    output int                      checks
);
    import scroll_pkg::*;

    scroll_reg_t next_reg [3];  // rendered now
    scroll_reg_t show_reg [3];  // on screen now
    vcnt_t       next_v;
    vcnt_t       show_v;
    int          edges;
    logic        last_start;
    logic        pend;
    int          pend_h;        // hdump the latched pixel belongs to

    // VRAM and ROM contents, same hashes as the memory models
    function automatic logic [15:0] vram_word(input logic [16:0] a);
        logic [31:0] h;
        h = {15'd0, a} * 32'h9e3779b1;
        return h[31:16] ^ {h[7:0], h[15:8]};
    endfunction

    function automatic logic [31:0] rom_word(input logic [19:0] a);
        logic [31:0] h;
        h = ({12'd0, a} ^ 32'h5bd1e995) * 32'h01000193;
        return h ^ {h[15:0], h[31:16]};
    endfunction

    // tile size s, map wraps at 32 tiles both ways
    function automatic pxl_t model_pixel(input int s, input scroll_reg_t r,
                                         input vcnt_t v, input int x);
        int          wrap;
        int          mx;
        int          my;
        int          va;
        int          ra;
        logic [15:0] code;
        logic [31:0] word;
        logic [3:0]  col;
        wrap = 32 * s;
        mx   = (x + int'(r.hpos)) % wrap;
        my   = (int'(v) + int'(r.vpos)) % wrap;
        va   = (int'(r.base) + (my / s) * `SCROLL_MAP_COLS + mx / s) % (1 << 17);
        code = vram_word(17'(va));
        ra   = (int'(code) * s * (s / 8) + (my % s) * (s / 8) + (mx % s) / 8) % (1 << 20);
        word = rom_word(20'(ra));
        col  = word[4 * (mx % 8) +: 4];
        return {code[6:0], col};
    endfunction

    task automatic check_pixel(input int layer, input pxl_t got);
        pxl_t exp;
        int   x;
        logic known;
        x     = pend_h - `SCROLL_H_START;
        known = 1'b1;
        if (x < 0 || x >= `SCROLL_LINE_W) begin
            exp = `SCROLL_BLANK;
        end else if (edges < 2) begin
            known = 1'b0;   // shown half not written yet
            exp   = '0;
        end else begin
            exp = model_pixel(8 << (layer - 1), show_reg[layer - 1], show_v, x);
        end
        if (known) begin
            checks++;
            if (got !== exp) begin
                errors++;
                $display("[ERROR] layer%0d line %0d x %0d: expected %h, actual %h",
                         layer, edges, x, exp, got);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            last_start = 1'b0;
            edges      = 0;
            pend       = 1'b0;
            pend_h     = 0;
        end else begin
            if (start && !last_start) begin
                show_reg    = next_reg;
                show_v      = next_v;
                next_reg[0] = layer1_reg;
                next_reg[1] = layer2_reg;
                next_reg[2] = layer3_reg;
                next_v      = vrender;
                edges++;
            end
            last_start = start;
            pend       = pxl_cen;
            pend_h     = (hdump == 9'd0) ? `SCROLL_H_TOTAL - 1 : int'(hdump) - 1;
        end
    end

    // outputs are registers, stable at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            errors = 0;
            checks = 0;
        end else begin
            if (edges == 0) begin
                if (vram_cs || rom_cs) begin
                    errors++;
                    $display("chip select went high before the first line start");
                end
                if (scr1_pxl !== `SCROLL_BLANK || scr2_pxl !== `SCROLL_BLANK ||
                    scr3_pxl !== `SCROLL_BLANK) begin
                    errors++;
                    $display("[ERROR] reset blank: expected %h, actual %h %h %h",
                             `SCROLL_BLANK, scr1_pxl, scr2_pxl, scr3_pxl);
                end
            end
            if (pend) begin
                check_pixel(1, scr1_pxl);
                check_pixel(2, scr2_pxl);
                check_pixel(3, scr3_pxl);
            end
        end
    end

endmodule

/* tb_scroll_properties.sv */
// handshake and sequencing assertions for the scroll renderer
// memory strobes, write enable steering and line start spacing
`timescale 1ns/100ps

module tb_scroll_properties (
    input logic        clk,
    input logic        rst,
    input logic        start_edge,
    input logic        busy,
    input logic        vram_cs,
    input logic        vram_ok,
    input logic [16:0] vram_addr,
    input logic        rom_cs,
    input logic        rom_ok,
    input logic [19:0] rom_addr,
    input logic [2:0]  wr_en,
    input logic        wr_half,
    input logic        rd_half
);
    vram_hold: assert property (@(posedge clk) disable iff (rst)
        vram_cs && !vram_ok && !start_edge |=> vram_cs && $stable(vram_addr))
        else $error("VRAM select dropped or address moved before ok");

    rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok && !start_edge |=> rom_cs && $stable(rom_addr))
        else $error("ROM select dropped or address moved before ok");

    // a write goes to one layer only and never into the half on screen
    one_writer: assert property (@(posedge clk) disable iff (rst)
        (wr_en != 3'b000) |-> $onehot(wr_en) && (wr_half != rd_half))
        else $error("line buffer write hit more than one layer or the shown half");

    start_idle: assert property (@(posedge clk) disable iff (rst) start_edge |-> !busy)
        else $error("line start arrived while a line was still rendering");

endmodule

bind scroll_top tb_scroll_properties props_inst (
    .clk(clk), .rst(rst), .start_edge(fetch_stop), .busy(seq_inst.busy),
    .vram_cs(vram_cs), .vram_ok(vram_ok), .vram_addr(vram_addr),
    .rom_cs(rom_cs), .rom_ok(rom_ok), .rom_addr(rom_addr), .wr_en(wr_en),
    .wr_half(wr_half), .rd_half(rd_half)
);

/* tb_scroll.sv */
// scroll renderer testbench
// raster counter, VRAM and ROM models with random stalls, random
// scroll registers per line; inputs change on the falling edge
`timescale 1ns/100ps
`include "scroll_defs.svh"

module tb_scroll;
    import scroll_pkg::*;

    localparam int NUM_LINES = 16;
    localparam int LINE_CLKS = 4 * `SCROLL_H_TOTAL;

    logic        clk;
    logic        rst;
    logic        pxl_cen    = 1'b0;
    hcnt_t       hdump      = 9'(`SCROLL_H_TOTAL - 1);
    vcnt_t       vrender    = 9'd0;
    logic        start      = 1'b0;
    scroll_reg_t layer1_reg = '0;
    scroll_reg_t layer2_reg = '0;
    scroll_reg_t layer3_reg = '0;
    logic [15:0] vram_data  = '0;
    logic        vram_ok    = 1'b0;
    logic [31:0] rom_data   = '0;
    logic        rom_ok     = 1'b0;
    vram_addr_t  vram_addr;
    logic        vram_cs;
    rom_addr_t   rom_addr;
    logic        rom_cs;
    pxl_t        scr1_pxl;
    pxl_t        scr2_pxl;
    pxl_t        scr3_pxl;

    int          seed      = 32'ha2031507;
    logic [1:0]  cen_cnt   = 2'd3;
    int          line_cnt  = 0;
    int          vram_wait = 0;
    int          rom_wait  = 0;
    int          timeouts  = 0;
    int          mismatches;
    int          checked;
    logic        run_ended = 1'b0;

    tb_clkgen clkgen_inst (.clk(clk), .rst(rst));

    scroll_top scroll_top_inst (
        .rst(rst), .clk(clk), .pxl_cen(pxl_cen), .hdump(hdump), .vrender(vrender),
        .start(start), .layer1_reg(layer1_reg), .layer2_reg(layer2_reg),
        .layer3_reg(layer3_reg), .vram_addr(vram_addr), .vram_cs(vram_cs),
        .vram_data(vram_data), .vram_ok(vram_ok), .rom_addr(rom_addr), .rom_cs(rom_cs),
        .rom_data(rom_data), .rom_ok(rom_ok),
        .scr1_pxl(scr1_pxl), .scr2_pxl(scr2_pxl), .scr3_pxl(scr3_pxl)
    );

    tb_checker checker_inst (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .start(start), .hdump(hdump),
        .vrender(vrender), .layer1_reg(layer1_reg), .layer2_reg(layer2_reg),
        .layer3_reg(layer3_reg), .vram_cs(vram_cs), .rom_cs(rom_cs),
        .scr1_pxl(scr1_pxl), .scr2_pxl(scr2_pxl), .scr3_pxl(scr3_pxl),
        .errors(mismatches), .checks(checked)
    );

    function automatic logic [15:0] vram_word(input logic [16:0] a);
        logic [31:0] h;
        h = {15'd0, a} * 32'h9e3779b1;
        return h[31:16] ^ {h[7:0], h[15:8]};
    endfunction

    function automatic logic [31:0] rom_word(input logic [19:0] a);
        logic [31:0] h;
        h = ({12'd0, a} ^ 32'h5bd1e995) * 32'h01000193;
        return h ^ {h[15:0], h[31:16]};
    endfunction

    // mostly no wait, one access in four may stall up to 3 clocks
    task automatic pick_delay(output int d);
        int r;
        r = $random(seed);
        d = (r[4:3] == 2'b00) ? int'(r[1:0]) : 0;
    endtask

    task automatic random_reg(output scroll_reg_t r);
        r.base = 16'($random(seed));
        r.hpos = 16'($random(seed));
        r.vpos = 16'($random(seed));
    endtask

    task automatic new_line();
        int which;
        line_cnt++;
        if (line_cnt % 4 == 0) begin
            // only one layer moves, the other two repeat their last line
            which = (line_cnt / 4) % 3;
            if (which == 0) begin
                random_reg(layer1_reg);
            end else if (which == 1) begin
                random_reg(layer2_reg);
            end else begin
                random_reg(layer3_reg);
            end
        end else begin
            vrender = vrender + 9'd1;
            random_reg(layer1_reg);
            random_reg(layer2_reg);
            random_reg(layer3_reg);
        end
    endtask

    task automatic advance_raster();
        if (cen_cnt == 2'd3) begin
            cen_cnt = 2'd0;
            pxl_cen = 1'b1;
            if (hdump == 9'(`SCROLL_H_TOTAL - 1)) begin
                hdump = 9'd0;
                new_line();
            end else begin
                hdump = hdump + 9'd1;
            end
        end else begin
            cen_cnt = cen_cnt + 2'd1;
            pxl_cen = 1'b0;
        end
        start = (hdump < 9'(`SCROLL_H_TOTAL / 2));  // rises at hdump 0
    endtask

    task automatic serve_vram();
        if (!vram_cs) begin
            vram_ok = 1'b0;
            pick_delay(vram_wait);
        end else if (!vram_ok) begin
            if (vram_wait == 0) begin
                vram_ok   = 1'b1;
                vram_data = vram_word(vram_addr);
            end else begin
                vram_wait--;
            end
        end
    endtask

    task automatic serve_rom();
        if (!rom_cs) begin
            rom_ok = 1'b0;
            pick_delay(rom_wait);
        end else if (!rom_ok) begin
            if (rom_wait == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_word(rom_addr);
            end else begin
                rom_wait--;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            advance_raster();
            serve_vram();
            serve_rom();
        end
    end

    task automatic wait_line(input int n);
        int count;
        count = 0;
        while (line_cnt < n && count < LINE_CLKS + 8) begin
            @(negedge clk);
            count++;
        end
        if (line_cnt < n) begin
            timeouts++;
            $display("line %0d never started", n);
        end
    endtask

    task automatic wait_done(input int n);
        int   count;
        logic seen;
        count = 0;
        seen  = 1'b0;
        while (!seen && line_cnt == n && count < LINE_CLKS) begin
            @(negedge clk);
            seen = scroll_top_inst.seq_inst.done;
            count++;
        end
        if (!seen) begin
            timeouts++;
            $display("line %0d did not finish rendering before the next line start", n);
        end
    endtask

    task automatic finish_run();
        run_ended = 1'b1;
        $display("errors: %0d check, %0d timeout, %0d pixels checked",
                 mismatches, timeouts, checked);
        if (mismatches == 0 && timeouts == 0 && checked > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        int count;
        count = 0;
        while (rst !== 1'b0 && count < 20) begin
            @(posedge clk);
            count++;
        end
        if (rst !== 1'b0) begin
            timeouts++;
            $display("reset never released");
        end
        for (int n = 1; n <= NUM_LINES; n++) begin
            wait_line(n);
            wait_done(n);
        end
        // last rendered line is shown during the line after it
        wait_line(NUM_LINES + 1);
        wait_line(NUM_LINES + 2);
        finish_run();
    end

    // run stopped before the closing report
    final begin
        if (!run_ended) begin
            $display("Simulation finished: FAIL");
        end
    end

endmodule

/* sim.f */
+incdir+.
scroll_pkg.sv
scroll_seq.sv
tile_fetch.sv
line_buf.sv
pxl_out.sv
scroll_top.sv
tb_clkgen.sv
tb_checker.sv
tb_scroll_properties.sv
tb_scroll.sv

/* run.sh */
#!/usr/bin/env bash
# build the scroll renderer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_scroll -f sim.f -o tb_scroll_sim \
    && ./obj_dir/tb_scroll_sim | tee /dev/stderr | grep -q "^Simulation finished: PASS$" \
    && { echo "run.sh: passed"; exit 0; } \
    || { echo "run.sh: failed"; exit 1; }
